/* project.f */
+incdir+common
common/fetch_pkg.sv
fetch/pc_select.sv
fetch/fetch_pair.sv
fetch/fetch_front.sv
test/tb_fetch_front.sv

/* test/tb_fetch_front.sv */
`timescale 1ns/100ps

`include "fetch_defines.svh"

module tb_fetch_front;
    import fetch_pkg::*;

    logic        clk;
    logic        reset;
    logic        i_stall;
    logic        i_flush;
    redirect_t   i_redirect;
    iresp_t      i_iresp;
    ireq_t       o_ireq;
    fetch_pair_t o_pair;

    integer seed;
    integer mem_rnd;
    integer err_count;
    integer test_err_start;
    integer tests_run;
    integer tests_failed;

    // reference pc and redirects waiting for a free edge
    addr_t exp_pc;
    logic  pend_exc_v;
    logic  pend_br_v;
    addr_t pend_exc_t;
    addr_t pend_br_t;
    // last address the bus took, and whether a jump came after it
    addr_t last_taken;
    logic  have_last;
    logic  jumped;

    logic  taken;
    logic  adv;
    logic  exc_hit;
    logic  br_hit;
    addr_t exc_tgt;
    addr_t br_tgt;

    fetch_front uut (
        .clk        (clk),
        .reset      (reset),
        .i_stall    (i_stall),
        .i_flush    (i_flush),
        .i_redirect (i_redirect),
        .i_iresp    (i_iresp),
        .o_ireq     (o_ireq),
        .o_pair     (o_pair)
    );

    always #50 clk = ~clk;

    // bus handshake that really moves the pc
    assign taken = o_ireq.valid && i_iresp.addr_ok && !i_stall;
    // pc moves unless held or an aligned request is still waiting
    assign adv = !i_stall && !((exp_pc[1:0] == 2'b00) && !i_iresp.addr_ok);
    // exception beats branch, newest pulse beats an older one
    assign exc_hit = pend_exc_v || i_redirect.exc_valid;
    assign exc_tgt = i_redirect.exc_valid ? i_redirect.exc_target : pend_exc_t;
    assign br_hit  = pend_br_v || i_redirect.branch_valid;
    assign br_tgt  = i_redirect.branch_valid ? i_redirect.branch_target : pend_br_t;

    always @(posedge clk) begin
        if (reset) begin
            exp_pc     <= `FETCH_RESET_VECTOR;
            pend_exc_v <= 1'b0;
            pend_br_v  <= 1'b0;
            have_last  <= 1'b0;
            jumped     <= 1'b0;
        end else begin
            if (adv) begin
                if (exc_hit) begin
                    exp_pc <= exc_tgt;
                end else if (br_hit) begin
                    exp_pc <= br_tgt;
                end else begin
                    exp_pc <= exp_pc + `FETCH_PAIR_STEP;
                end
                pend_exc_v <= 1'b0;
                pend_br_v  <= 1'b0;
            end else begin
                pend_exc_v <= exc_hit;
                pend_exc_t <= exc_tgt;
                pend_br_v  <= br_hit;
                pend_br_t  <= br_tgt;
            end
            if (taken) begin
                have_last  <= 1'b1;
                last_taken <= o_ireq.addr;
                jumped     <= exc_hit || br_hit;
            end else if (adv && (exc_hit || br_hit)) begin
                jumped <= 1'b1;
            end
        end
    end

    // memory model, each word of the pair holds its own address
    always @(posedge clk) begin
        if (reset) begin
            i_iresp <= '0;
        end else begin
            if (o_ireq.valid && i_iresp.addr_ok) begin
                i_iresp.data <= {o_ireq.addr + 32'd4, o_ireq.addr};
            end
            mem_rnd = $random(seed);
            i_iresp.addr_ok <= (mem_rnd[1:0] != 2'b00);
        end
    end

    task automatic note_mismatch(input string msg);
        $display("Fail %0t: %s", $time, msg);
        err_count = err_count + 1;
    endtask

    a_reset_slots: assert property (@(posedge clk)
        reset |=> !o_pair[0].valid && !o_pair[1].valid)
        else note_mismatch("output slot valid after a reset edge");
    a_first_req: assert property (@(posedge clk)
        $fell(reset) |-> o_ireq.valid && o_ireq.addr == `FETCH_RESET_VECTOR)
        else note_mismatch("first request is not the reset vector");
    a_pc_track: assert property (@(posedge clk) disable iff (reset)
        o_ireq.addr == exp_pc)
        else note_mismatch($sformatf("fetch pc %h, expected %h",
            $sampled(o_ireq.addr), $sampled(exp_pc)));
    a_req_valid: assert property (@(posedge clk) disable iff (reset)
        o_ireq.valid == (exp_pc[1:0] == 2'b00))
        else note_mismatch("request valid does not follow pc alignment");
    a_seq_step: assert property (@(posedge clk) disable iff (reset)
        taken && have_last && !jumped |-> o_ireq.addr == last_taken + `FETCH_PAIR_STEP)
        else note_mismatch("sequential fetch did not step by one pair");
    a_slot0_instr: assert property (@(posedge clk) disable iff (reset)
        o_pair[0].valid && o_pair[0].exc == exc_none |-> o_pair[0].instr == o_pair[0].pc)
        else note_mismatch("slot 0 instruction differs from its pc");
    a_slot1_instr: assert property (@(posedge clk) disable iff (reset)
        o_pair[1].valid |-> o_pair[1].instr == o_pair[1].pc
            && o_pair[1].pc == o_pair[0].pc + `FETCH_SLOT_STEP
            && o_pair[1].exc == exc_none)
        else note_mismatch("slot 1 instruction, pc or exception code is wrong");
    a_slot1_valid: assert property (@(posedge clk) disable iff (reset)
        o_pair[0].valid && o_pair[0].exc == exc_none |-> o_pair[1].valid)
        else note_mismatch("clean slot 0 without a valid slot 1");
    a_exc_slot: assert property (@(posedge clk) disable iff (reset)
        o_pair[0].valid && o_pair[0].exc == exc_adel_fetch
            |-> o_pair[0].instr == '0 && !o_pair[1].valid && o_pair[0].pc[1:0] != 2'b00)
        else note_mismatch("misaligned fetch slot is malformed");
    a_exc_code: assert property (@(posedge clk) disable iff (reset)
        o_pair[0].valid && o_pair[0].pc[1:0] != 2'b00 |-> o_pair[0].exc == exc_adel_fetch)
        else note_mismatch("misaligned slot without fetch exception");
    a_out_hold: assert property (@(posedge clk) disable iff (reset)
        i_stall && !i_flush |=> $stable(o_pair))
        else note_mismatch("output pair changed while stalled");
    a_flush_kill: assert property (@(posedge clk) disable iff (reset)
        i_flush |=> !o_pair[0].valid && !o_pair[1].valid)
        else note_mismatch("output pair valid after flush");

    task automatic tick(input integer n);
        repeat (n) @(posedge clk);
    endtask

    // one-cycle redirect pulse
    task automatic send_redirect(input logic ev, input addr_t et, input logic bv,
                                 input addr_t bt);
        redirect_t r;
        r.exc_valid     = ev;
        r.exc_target    = et;
        r.branch_valid  = bv;
        r.branch_target = bt;
        i_redirect <= r;
        @(posedge clk);
        i_redirect <= '0;
    endtask

    task automatic wait_fetch(input addr_t addr, input integer limit);
        integer n;
        logic   found;
        n = 0;
        found = 1'b0;
        while (!found && n < limit) begin
            @(posedge clk);
            found = taken && (o_ireq.addr == addr);
            n = n + 1;
        end
        if (!found) begin
            $display("timeout: address %h was never fetched", addr);
            err_count = err_count + 1;
        end
    endtask

    // count valid output pairs, misaligned ones only if asked
    task automatic wait_pairs(input integer count, input logic exc_only,
                              input integer limit);
        integer n;
        integer seen;
        n = 0;
        seen = 0;
        while (seen < count && n < limit) begin
            @(posedge clk);
            if (o_pair[0].valid && (!exc_only || o_pair[0].exc == exc_adel_fetch)) begin
                seen = seen + 1;
            end
            n = n + 1;
        end
        if (seen < count) begin
            $display("timeout: only %0d of %0d output pairs arrived", seen, count);
            err_count = err_count + 1;
        end
    endtask

    task automatic start_test();
        test_err_start = err_count;
    endtask

    task automatic finish_test(input string name);
        tests_run = tests_run + 1;
        if (err_count != test_err_start) begin
            tests_failed = tests_failed + 1;
            $display("test %s: FAIL, %0d errors", name, err_count - test_err_start);
        end else begin
            $display("test %s: ok", name);
        end
    endtask

    initial begin
        clk = 1'b0;
        reset = 1'b1;
        i_stall = 1'b0;
        i_flush = 1'b0;
        i_redirect = '0;
        i_iresp = '0;
        seed = 32'h267f2fe8;
        err_count = 0;
        tests_run = 0;
        tests_failed = 0;

        start_test();
        tick(8);
        reset <= 1'b0;
        wait_fetch(`FETCH_RESET_VECTOR, 50);
        finish_test("reset");

        start_test();
        wait_fetch(`FETCH_RESET_VECTOR + 32'd192, 400);
        wait_pairs(8, 1'b0, 200);
        finish_test("sequential");

        // both pulses at once, exception must win
        start_test();
        send_redirect(1'b1, 32'h8000_1000, 1'b1, 32'h8000_2000);
        wait_fetch(32'h8000_1000, 100);
        tick(4);
        send_redirect(1'b0, '0, 1'b1, 32'h8000_3000);
        wait_fetch(32'h8000_3000, 100);
        finish_test("redirect priority");

        // redirects landing inside a stall window
        start_test();
        i_stall <= 1'b1;
        tick(2);
        send_redirect(1'b0, '0, 1'b1, 32'h8000_4000);
        tick(1);
        send_redirect(1'b1, 32'h8000_5000, 1'b0, '0);
        send_redirect(1'b0, '0, 1'b1, 32'h8000_6000);
        tick(2);
        i_stall <= 1'b0;
        wait_fetch(32'h8000_5000, 100);
        tick(4);
        i_stall <= 1'b1;
        tick(1);
        send_redirect(1'b0, '0, 1'b1, 32'h8000_7000);
        tick(2);
        i_stall <= 1'b0;
        wait_fetch(32'h8000_7000, 100);
        finish_test("saved redirect");

        // jump to a misaligned pc, then back
        start_test();
        send_redirect(1'b0, '0, 1'b1, 32'h8000_8102);
        wait_pairs(1, 1'b1, 100);
        send_redirect(1'b0, '0, 1'b1, 32'h8000_9000);
        wait_fetch(32'h8000_9000, 100);
        finish_test("misaligned target");

        start_test();
        wait_pairs(1, 1'b0, 100);
        i_stall <= 1'b1;
        tick(6);
        i_stall <= 1'b0;
        wait_pairs(6, 1'b0, 200);
        i_flush <= 1'b1;
        tick(1);
        i_flush <= 1'b0;
        wait_pairs(6, 1'b0, 200);
        finish_test("hold and flush");

        tick(3);
        $display("tests run %0d, passed %0d, failed %0d", tests_run,
                 tests_run - tests_failed, tests_failed);
        if (err_count == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

/* fetch/fetch_front.sv */
`timescale 1ns/100ps

module fetch_front (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   i_stall,
    input  logic                   i_flush,
    input  fetch_pkg::redirect_t   i_redirect,
    input  fetch_pkg::iresp_t      i_iresp,
    output fetch_pkg::ireq_t       o_ireq,
    output fetch_pkg::fetch_pair_t o_pair
);
    import fetch_pkg::*;

    // request out but not taken by the bus yet
    logic i_wait;
    // merged fetch stall, holds pc and f1
    logic stall_f;

    f1_data_t f1_next;

    assign i_wait  = o_ireq.valid && !i_iresp.addr_ok;
    assign stall_f = i_stall || i_wait;

    // pc, redirect priority, request
    pc_select u_pc_select (
        .clk        (clk),
        .reset      (reset),
        .i_stall    (stall_f),
        .i_redirect (i_redirect),
        .o_ireq     (o_ireq),
        .o_f1_next  (f1_next)
    );

    // f1 register, hold buffer, slot split
    fetch_pair u_fetch_pair (
        .clk        (clk),
        .reset      (reset),
        .i_stall_f  (stall_f),
        .i_stall    (i_stall),
        .i_flush    (i_flush),
        .i_f1_next  (f1_next),
        .i_data     (i_iresp.data),
        .o_pair     (o_pair)
    );

endmodule

/* fetch/fetch_pair.sv */
`timescale 1ns/100ps

`include "fetch_defines.svh"

module fetch_pair (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     i_stall_f,
    input  logic                     i_stall,
    input  logic                     i_flush,
    input  fetch_pkg::f1_data_t      i_f1_next,
    input  logic [2*`FETCH_INSTR_W-1:0] i_data,
    output fetch_pkg::fetch_pair_t   o_pair
);
    import fetch_pkg::*;

    // f1 stage register
    f1_data_t f1_q;

    // one-entry hold for data returned under a stall
    logic                        hold_valid_q;
    logic [2*`FETCH_INSTR_W-1:0] hold_data_q;

    // flush seen last cycle
    logic flush_d_q;

    // data feeding the slots this cycle
    logic [2*`FETCH_INSTR_W-1:0] raw_data;
    fetch_pair_t                 pair_nxt;

    // f1 moves with the pc, flush drops the entry
    always_ff @(posedge clk) begin
        if (reset || i_flush) begin
            f1_q.valid <= 1'b0;
        end else if (!i_stall_f) begin
            f1_q <= i_f1_next;
        end
    end

    // response data only stays until the next acceptance,
    // so grab it on the first held cycle
    // released once f1 is free to advance again
    always_ff @(posedge clk) begin
        if (reset || i_flush) begin
            hold_valid_q <= 1'b0;
        end else if (!i_stall_f) begin
            hold_valid_q <= 1'b0;
        end else if (!hold_valid_q) begin
            hold_valid_q <= 1'b1;
            hold_data_q  <= i_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            flush_d_q <= 1'b0;
        end else begin
            flush_d_q <= i_flush;
        end
    end

    // held copy first, then stale data after a flush
    always_comb begin
        if (hold_valid_q) begin
            raw_data = hold_data_q;
        end else if (flush_d_q) begin
            raw_data = '0;
        end else begin
            raw_data = i_data;
        end
    end

    // split into slots
    // the pair is issued once, on the edge where f1 advances
    always_comb begin
        pair_nxt[0].valid = f1_q.valid && !i_stall_f;
        pair_nxt[0].pc    = f1_q.pc;
        pair_nxt[0].exc   = f1_q.exc;
        // exception slot carries a zero instruction
        if (f1_q.exc != exc_none) begin
            pair_nxt[0].instr = '0;
        end else begin
            pair_nxt[0].instr = raw_data[`FETCH_INSTR_W-1:0];
        end

        // second word only behind a clean first one
        pair_nxt[1].valid = pair_nxt[0].valid && (f1_q.exc == exc_none);
        pair_nxt[1].pc    = f1_q.pc + `FETCH_SLOT_STEP;
        pair_nxt[1].instr = raw_data[2*`FETCH_INSTR_W-1:`FETCH_INSTR_W];
        pair_nxt[1].exc   = exc_none;
    end

    // output register, held under back-pressure
    always_ff @(posedge clk) begin
        if (reset || i_flush) begin
            o_pair[0].valid <= 1'b0;
            o_pair[1].valid <= 1'b0;
        end else if (!i_stall) begin
            o_pair <= pair_nxt;
        end
    end

    a_slot_order: assert property (
        @(posedge clk) disable iff (reset)
        o_pair[1].valid |-> o_pair[0].valid
    ) else $error("slot 1 valid without slot 0");

endmodule

/* fetch/pc_select.sv */
`timescale 1ns/100ps

`include "fetch_defines.svh"

module pc_select (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 i_stall,
    input  fetch_pkg::redirect_t i_redirect,
    output fetch_pkg::ireq_t     o_ireq,
    output fetch_pkg::f1_data_t  o_f1_next
);
    import fetch_pkg::*;

    // fetch pc and its successor
    addr_t pc_q;
    addr_t pc_nxt;
    addr_t seq_pc;
    logic  pc_aligned;

    // redirects seen while stalled
    logic  exc_saved_q;
    logic  branch_saved_q;
    addr_t exc_save_q;
    addr_t branch_save_q;

    pc_src_e pc_src;

    assign seq_pc = pc_q + `FETCH_PAIR_STEP;
    assign pc_aligned = (pc_q[1:0] == 2'b00);

    // next pc by fixed priority
    // live exc > saved exc > live branch > saved branch > seq
    always_comb begin
        if (i_redirect.exc_valid) begin
            pc_src = src_exc;
            pc_nxt = i_redirect.exc_target;
        end else if (exc_saved_q) begin
            pc_src = src_saved_exc;
            pc_nxt = exc_save_q;
        end else if (i_redirect.branch_valid) begin
            pc_src = src_branch;
            pc_nxt = i_redirect.branch_target;
        end else if (branch_saved_q) begin
            pc_src = src_saved_branch;
            pc_nxt = branch_save_q;
        end else begin
            pc_src = src_seq;
            pc_nxt = seq_pc;
        end
    end

    // pc only moves on a free edge
    always_ff @(posedge clk) begin
        if (reset) begin
            pc_q <= `FETCH_RESET_VECTOR;
        end else if (!i_stall) begin
            pc_q <= pc_nxt;
        end
    end

    // catch redirects that land while fetch is held
    // the free edge consumes them through pc_nxt, then both clear
    always_ff @(posedge clk) begin
        if (reset) begin
            exc_saved_q    <= 1'b0;
            branch_saved_q <= 1'b0;
        end else if (!i_stall) begin
            exc_saved_q    <= 1'b0;
            branch_saved_q <= 1'b0;
        end else if (i_redirect.exc_valid) begin
            exc_saved_q    <= 1'b1;
            exc_save_q     <= i_redirect.exc_target;
            // an exception kills any pending branch
            branch_saved_q <= 1'b0;
        end else if (i_redirect.branch_valid && !exc_saved_q) begin
            branch_saved_q <= 1'b1;
            branch_save_q  <= i_redirect.branch_target;
        end
    end

    // misaligned pc never goes to the bus
    always_comb begin
        o_ireq.valid = pc_aligned;
        o_ireq.addr  = pc_q;
    end

    // f1 entry, carries the fetch exception along
    always_comb begin
        o_f1_next.valid = 1'b1;
        o_f1_next.pc    = pc_q;
        o_f1_next.exc   = pc_aligned ? exc_none : exc_adel_fetch;
    end

    a_req_aligned: assert property (
        @(posedge clk) disable iff (reset)
        o_ireq.valid |-> (o_ireq.addr[1:0] == 2'b00) && (o_f1_next.exc == exc_none)
    ) else $error("request with misaligned address %h", o_ireq.addr);

    a_saved_excl: assert property (
        @(posedge clk) disable iff (reset)
        !(exc_saved_q && branch_saved_q)
    ) else $error("saved branch and saved exception both pending");

    // a saved redirect is spent on the first free edge
    a_saved_once: assert property (
        @(posedge clk) disable iff (reset)
        (pc_src == src_saved_exc || pc_src == src_saved_branch) |-> $past(i_stall)
    ) else $error("saved redirect outlived a free edge");

endmodule

/* common/fetch_pkg.sv */
`include "fetch_defines.svh"

package fetch_pkg;

    typedef logic [`FETCH_ADDR_W-1:0] addr_t;
    typedef logic [`FETCH_INSTR_W-1:0] instr_t;

    // fetch-side exception code, only misalignment is left
    typedef enum logic {
        exc_none,
        exc_adel_fetch
    } fetch_exc_e;

    // where the next pc came from
    typedef enum logic [2:0] {
        src_seq,
        src_branch,
        src_exc,
        src_saved_branch,
        src_saved_exc
    } pc_src_e;

    // redirect pulses from execute / cp0
    typedef struct packed {
        logic  exc_valid;
        addr_t exc_target;
        logic  branch_valid;
        addr_t branch_target;
    } redirect_t;

    // instruction bus request
    typedef struct packed {
        logic  valid;
        addr_t addr;
    } ireq_t;

    // instruction bus response, low half is the older instruction
    typedef struct packed {
        logic                       addr_ok;
        logic [2*`FETCH_INSTR_W-1:0] data;
    } iresp_t;

    // entry between pc select and f1
    typedef struct packed {
        logic       valid;
        addr_t      pc;
        fetch_exc_e exc;
    } f1_data_t;

    // one decoded-ready slot
    typedef struct packed {
        logic       valid;
        addr_t      pc;
        instr_t     instr;
        fetch_exc_e exc;
    } fetch_slot_t;

    // slot 0 is the older instruction
    typedef fetch_slot_t [1:0] fetch_pair_t;

endpackage

/* common/fetch_defines.svh */
`ifndef FETCH_DEFINES_SVH
`define FETCH_DEFINES_SVH

// first fetch address after reset
`define FETCH_RESET_VECTOR 32'hbfc0_0000

// address and instruction widths
`define FETCH_ADDR_W 32
`define FETCH_INSTR_W 32

// one fetch pair is two words, 8 bytes
`define FETCH_PAIR_STEP 8

// byte offset of the second slot in a pair
`define FETCH_SLOT_STEP 4

`endif
